// File: bf_fault_injector.f
+incdir+include
design/bf_pkg.sv
design/bf_delay_line.sv
design/bf_hash.sv
design/bf_bit_array.sv
design/bf_channel_lookup.sv
design/bf_command_decoder.sv
design/bf_fault_select.sv
design/bf_fault_injector.sv
bench/bf_fault_checker.sv
bench/bf_fault_injector_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := bf_fault_injector_tb
FILELIST   := bf_fault_injector.f
BUILD_DIR  := obj_dir
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
RUN_ARGS   := +verilator+error+limit+1000
LOG        := sim.log
PASS_MSG   := Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/bf_fault_injector_tb.sv
`timescale 1ns/10ps
`include "bf_defs.svh"

module bf_fault_injector_tb import bf_pkg::*; ();

    typedef struct {
        logic [`BF_CSR_W-1:0] csr;
        bf_addr_t             ar_addr;
        bf_addr_t             aw_addr;
        logic [`BF_ID_W-1:0]  arid;
        logic [`BF_ID_W-1:0]  awid;
        logic                 arvalid;
        logic                 awvalid;
        logic                 exp_ar;
        logic                 exp_aw;
    } row_t;

    logic                 clk;
    logic                 rst_n;
    logic [`BF_CSR_W-1:0] csr_data;
    bf_addr_t             addr_ar;
    bf_addr_t             addr_aw;
    logic [`BF_ID_W-1:0]  arid;
    logic                 arvalid;
    logic [`BF_ID_W-1:0]  awid;
    logic                 awvalid;
    logic [`BF_ID_W-1:0]  arid_bf;
    logic                 arvalid_bf;
    logic [`BF_ID_W-1:0]  awid_bf;
    logic                 awvalid_bf;
    logic                 ar_is_faulty;
    logic                 aw_is_faulty;

    row_t     rows[$];
    bf_addr_t keys[$];
    bit       filter_bits [`BF_NUM_STACKS][`BF_FILTER_SIZE];
    integer   seed = 32'hd2a5_cef7;
    int       check_count = 0;
    int       error_count = 0;
    int       timeout_count = 0;
    bit       settled;

    bf_fault_injector i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .csr_data    (csr_data),
        .addr_ar     (addr_ar),
        .addr_aw     (addr_aw),
        .arid        (arid),
        .arvalid     (arvalid),
        .awid        (awid),
        .awvalid     (awvalid),
        .arid_bf     (arid_bf),
        .arvalid_bf  (arvalid_bf),
        .awid_bf     (awid_bf),
        .awvalid_bf  (awvalid_bf),
        .ar_is_faulty(ar_is_faulty),
        .aw_is_faulty(aw_is_faulty)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        return $random(seed);
    endfunction

    function automatic bf_addr_t any_addr();
        logic [31:0] r;
        r = next_random();
        return r[`BF_ADDR_W-1:0];
    endfunction

    function automatic logic [`BF_ID_W-1:0] any_id();
        logic [31:0] r;
        r = next_random();
        return r[`BF_ID_W-1:0];
    endfunction

    function automatic logic coin_flip();
        logic [31:0] r;
        r = next_random();
        return r[0];
    endfunction

    // data word with the key in bits 33:7 and junk elsewhere
    function automatic logic [`BF_CSR_W-1:0] key_word(input bf_addr_t key);
        logic [`BF_CSR_W-1:0] w;
        w = {next_random(), next_random()};
        w[33:7] = key;
        return w;
    endfunction

    // xorshift hashes whose shifts shrink by one per stack
    function automatic logic [`BF_INDEX_W-1:0] hash_index(input int stack, input bit second,
                                                          input bf_addr_t k);
        logic [31:0] kk;
        logic [31:0] x;
        kk = {5'b0, k};
        if (!second) begin
            x = kk ^ (kk >> (13 - stack));
            x = x ^ (x >> (7 - stack));
        end else begin
            x = kk ^ `BF_HASH_SEED ^ (kk >> (11 - stack));
            x = x ^ (x >> (3 - stack));
        end
        return x[`BF_INDEX_W-1:0];
    endfunction

    function automatic bit is_member(input bf_addr_t a);
        bit hit;
        hit = 1'b1;
        for (int s = 0; s < `BF_NUM_STACKS; s++) begin
            hit &= filter_bits[s][hash_index(s, 1'b0, a)];
            hit &= filter_bits[s][hash_index(s, 1'b1, a)];
        end
        return hit;
    endfunction

    function automatic void write_key(input bf_addr_t k, input bit value);
        for (int s = 0; s < `BF_NUM_STACKS; s++) begin
            filter_bits[s][hash_index(s, 1'b0, k)] = value;
            filter_bits[s][hash_index(s, 1'b1, k)] = value;
        end
    endfunction

    function automatic bit decode_command(input logic [`BF_CSR_W-1:0] w, inout bf_mode_t m);
        bit hit;
        hit = 1'b1;
        case (w)
            `BF_CMD_IDLE:       m = MODE_IDLE;
            `BF_CMD_INSERT:     m = MODE_INSERT;
            `BF_CMD_REMOVE:     m = MODE_REMOVE;
            `BF_CMD_CHECK:      m = MODE_CHECK;
            `BF_CMD_LOAD_CODE:  m = MODE_LOAD_CODE;
            `BF_CMD_MATCH_CODE: m = MODE_MATCH_CODE;
            default:            hit = 1'b0;
        endcase
        return hit;
    endfunction

    task automatic add_row(input logic [`BF_CSR_W-1:0] csr, input bf_addr_t ar_addr,
                           input bf_addr_t aw_addr, input logic ar_v, input logic aw_v);
        row_t r;
        r.csr     = csr;
        r.ar_addr = ar_addr;
        r.aw_addr = aw_addr;
        r.arid    = any_id();
        r.awid    = any_id();
        r.arvalid = ar_v;
        r.awvalid = aw_v;
        r.exp_ar  = 1'b0;
        r.exp_aw  = 1'b0;
        rows.push_back(r);
    endtask

    task automatic build_table();
        bf_addr_t mask;
        bf_addr_t code;
        bf_addr_t a;
        // idle pass-through
        add_row(`BF_CMD_IDLE, any_addr(), any_addr(), 1'b1, 1'b1);
        repeat (3) add_row('0, any_addr(), any_addr(), 1'b1, coin_flip());
        // inserts with requests alongside them
        add_row(`BF_CMD_INSERT, any_addr(), any_addr(), 1'b1, 1'b1);
        repeat (6) begin
            keys.push_back(any_addr());
            add_row(key_word(keys[$]), keys[$], any_addr(), 1'b1, 1'b1);
        end
        add_row(`BF_CMD_CHECK, any_addr(), any_addr(), 1'b0, 1'b0);
        // back-to-back members and then strangers
        foreach (keys[i]) add_row('0, keys[i], keys[(i + 1) % keys.size()], 1'b1, 1'b1);
        repeat (8) add_row('0, any_addr(), any_addr(), coin_flip(), coin_flip());
        // drop the first key
        add_row(`BF_CMD_REMOVE, keys[0], keys[1], 1'b1, 1'b1);
        add_row(key_word(keys[0]), keys[0], keys[0], 1'b1, 1'b1);
        add_row(`BF_CMD_CHECK, keys[0], keys[0], 1'b1, 1'b1);
        foreach (keys[i]) add_row('0, keys[i], keys[i], 1'b1, 1'b1);
        // good code word and then one with a bad marker that must not load
        mask = any_addr();
        code = any_addr();
        add_row(`BF_CMD_LOAD_CODE, any_addr(), any_addr(), 1'b0, 1'b0);
        add_row({`BF_MARK_HI, mask, code, `BF_MARK_LO}, any_addr(), any_addr(), 1'b0, 1'b0);
        add_row({5'b01011, ~mask, ~code, `BF_MARK_LO}, any_addr(), any_addr(), 1'b0, 1'b0);
        add_row(`BF_CMD_MATCH_CODE, code, keys[1], 1'b1, 1'b1);
        repeat (12) begin
            a = (code & mask) | (any_addr() & ~mask);
            add_row('0, coin_flip() ? a : any_addr(), coin_flip() ? keys[2] : any_addr(),
                    1'b1, 1'b1);
        end
        add_row(`BF_CMD_IDLE, keys[3], keys[3], 1'b1, 1'b1);
        add_row('0, keys[3], keys[3], 1'b1, 1'b1);
    endtask

    // flags use the mode as of this row
    // the code match uses mode and mask from two rows back
    task automatic fill_expected();
        bf_mode_t mode_cur;
        bf_mode_t mode_old;
        bf_mode_t mode_new;
        bf_addr_t mask_cur;
        bf_addr_t mask_old;
        bf_addr_t code_cur;
        bf_addr_t code_old;
        bf_addr_t last_key;
        bf_addr_t look_ar;
        bf_addr_t look_aw;
        bit       cmd;
        bit       wrote;
        bit       match;
        mode_cur = MODE_IDLE;
        mode_old = MODE_IDLE;
        mask_cur = '0;
        mask_old = '0;
        code_cur = '0;
        code_old = '0;
        last_key = '0;
        wrote    = 1'b0;
        foreach (rows[k]) begin
            mode_new = mode_cur;
            cmd = decode_command(rows[k].csr, mode_new);
            // a write in the row before takes over the lookup port
            look_ar = wrote ? last_key : rows[k].ar_addr;
            look_aw = wrote ? last_key : rows[k].aw_addr;
            match = (mode_old == MODE_MATCH_CODE) &&
                    ((rows[k].ar_addr & mask_old) == (code_old & mask_old));
            if (mode_new == MODE_CHECK) begin
                rows[k].exp_ar = rows[k].arvalid && is_member(look_ar);
                rows[k].exp_aw = rows[k].awvalid && is_member(look_aw);
            end else if (mode_new == MODE_MATCH_CODE) begin
                rows[k].exp_ar = rows[k].arvalid && match;
                rows[k].exp_aw = rows[k].awvalid && is_member(look_aw);
            end
            mode_old = mode_cur;
            mask_old = mask_cur;
            code_old = code_cur;
            last_key = rows[k].csr[33:7];
            wrote = ((mode_cur == MODE_INSERT) || (mode_cur == MODE_REMOVE)) && !cmd;
            if (wrote) begin
                write_key(last_key, mode_cur == MODE_INSERT);
            end
            if ((mode_cur == MODE_LOAD_CODE) && (rows[k].csr[63:59] == `BF_MARK_HI) &&
                (rows[k].csr[4:0] == `BF_MARK_LO)) begin
                mask_cur = rows[k].csr[58:32];
                code_cur = rows[k].csr[31:5];
            end
            mode_cur = mode_new;
        end
    endtask

    task automatic drive_row(input row_t r);
        csr_data = r.csr;
        addr_ar  = r.ar_addr;
        addr_aw  = r.aw_addr;
        arid     = r.arid;
        awid     = r.awid;
        arvalid  = r.arvalid;
        awvalid  = r.awvalid;
    endtask

    task automatic drive_idle();
        csr_data = '0;
        addr_ar  = '0;
        addr_aw  = '0;
        arid     = '0;
        awid     = '0;
        arvalid  = 1'b0;
        awvalid  = 1'b0;
    endtask

    task automatic check_value(input string what, input int row, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAIL %0t: row %0d %s is %0h, expected %0h", $time, row, what, got, exp);
        end
    endtask

    task automatic compare_row(input int r);
        check_value("arvalid_bf", r, 32'(arvalid_bf), 32'(rows[r].arvalid));
        check_value("arid_bf", r, 32'(arid_bf), 32'(rows[r].arid));
        check_value("awvalid_bf", r, 32'(awvalid_bf), 32'(rows[r].awvalid));
        check_value("awid_bf", r, 32'(awid_bf), 32'(rows[r].awid));
        check_value("ar_is_faulty", r, 32'(ar_is_faulty), 32'(rows[r].exp_ar));
        check_value("aw_is_faulty", r, 32'(aw_is_faulty), 32'(rows[r].exp_aw));
    endtask

    task automatic wait_outputs_idle(output bit ok);
        int cycles;
        cycles = 0;
        ok = 1'b0;
        while (!ok && cycles < 16) begin
            if (arvalid_bf === 1'b0 && awvalid_bf === 1'b0 &&
                ar_is_faulty === 1'b0 && aw_is_faulty === 1'b0) begin
                ok = 1'b1;
            end else begin
                @(negedge clk);
                cycles++;
            end
        end
        if (!ok) begin
            timeout_count++;
            $display("timeout: valids and flags did not go low after reset");
        end
    endtask

    // outputs of row k show up two edges later
    task automatic run_table();
        for (int k = 0; k < rows.size() + `BF_READ_LATENCY; k++) begin
            @(negedge clk);
            if (k >= `BF_READ_LATENCY) begin
                compare_row(k - `BF_READ_LATENCY);
            end
            if (k < rows.size()) begin
                drive_row(rows[k]);
            end else begin
                drive_idle();
            end
        end
    endtask

    task automatic finish_run();
        int assert_count;
        assert_count = i_dut.i_checker.assert_errors;
        $display("checks %0d, value errors %0d, assertion errors %0d, timeouts %0d",
                 check_count, error_count, assert_count, timeout_count);
        if (error_count == 0 && assert_count == 0 && timeout_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    endtask

    initial begin
        rst_n = 1'b0;
        drive_idle();
        build_table();
        fill_expected();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        wait_outputs_idle(settled);
        if (settled) begin
            run_table();
        end
        finish_run();
    end

endmodule

// File: bench/bf_fault_checker.sv
`timescale 1ns/10ps
`include "bf_defs.svh"

module bf_fault_checker import bf_pkg::*; (
    input logic     clk,
    input logic     rst_n,
    input bf_mode_t mode,
    input logic     arvalid_bf,
    input logic     awvalid_bf,
    input logic     ar_is_faulty,
    input logic     aw_is_faulty
);

    int assert_errors = 0;

    // a flag always rides on a live request
    ar_flag_valid: assert property (@(posedge clk) disable iff (!rst_n)
        ar_is_faulty |-> arvalid_bf)
        else begin
            assert_errors++;
            $error("read flag raised without a valid read");
        end

    aw_flag_valid: assert property (@(posedge clk) disable iff (!rst_n)
        aw_is_faulty |-> awvalid_bf)
        else begin
            assert_errors++;
            $error("write flag raised without a valid write");
        end

    // only check and match-code raise flags
    quiet_modes: assert property (@(posedge clk) disable iff (!rst_n)
        (mode != MODE_CHECK) && (mode != MODE_MATCH_CODE) |-> !ar_is_faulty && !aw_is_faulty)
        else begin
            assert_errors++;
            $error("flag raised in a mode without fault injection");
        end

    reset_clears: assert property (@(posedge clk)
        !rst_n |=> !arvalid_bf && !awvalid_bf)
        else begin
            assert_errors++;
            $error("valid still high after reset");
        end

endmodule

bind bf_fault_injector bf_fault_checker i_checker (
    .clk         (clk),
    .rst_n       (rst_n),
    .mode        (mode),
    .arvalid_bf  (arvalid_bf),
    .awvalid_bf  (awvalid_bf),
    .ar_is_faulty(ar_is_faulty),
    .aw_is_faulty(aw_is_faulty)
);

// File: design/bf_fault_injector.sv
`timescale 1ns/10ps
`include "bf_defs.svh"

module bf_fault_injector import bf_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [`BF_CSR_W-1:0] csr_data,
    input  bf_addr_t             addr_ar,
    input  bf_addr_t             addr_aw,
    input  logic [`BF_ID_W-1:0]  arid,
    input  logic                 arvalid,
    input  logic [`BF_ID_W-1:0]  awid,
    input  logic                 awvalid,
    output logic [`BF_ID_W-1:0]  arid_bf,
    output logic                 arvalid_bf,
    output logic [`BF_ID_W-1:0]  awid_bf,
    output logic                 awvalid_bf,
    output logic                 ar_is_faulty,
    output logic                 aw_is_faulty
);

    bf_mode_t mode;
    bf_addr_t key;
    bf_addr_t mask;
    bf_addr_t code;
    logic     wr_en;
    logic     wr_bit;
    logic     ar_member;
    logic     aw_member;

    bf_command_decoder i_decoder (
        .clk     (clk),
        .rst_n   (rst_n),
        .csr_data(csr_data),
        .mode    (mode),
        .key     (key),
        .wr_en   (wr_en),
        .wr_bit  (wr_bit),
        .mask    (mask),
        .code    (code)
    );

    // one filter copy per channel, written together
    bf_channel_lookup i_ar_lookup (
        .clk   (clk),
        .addr  (addr_ar),
        .key   (key),
        .wr_en (wr_en),
        .wr_bit(wr_bit),
        .member(ar_member)
    );

    bf_channel_lookup i_aw_lookup (
        .clk   (clk),
        .addr  (addr_aw),
        .key   (key),
        .wr_en (wr_en),
        .wr_bit(wr_bit),
        .member(aw_member)
    );

    bf_fault_select i_fault_select (
        .clk         (clk),
        .rst_n       (rst_n),
        .mode        (mode),
        .mask        (mask),
        .code        (code),
        .addr_ar     (addr_ar),
        .arid        (arid),
        .arvalid     (arvalid),
        .awid        (awid),
        .awvalid     (awvalid),
        .ar_member   (ar_member),
        .aw_member   (aw_member),
        .arid_bf     (arid_bf),
        .arvalid_bf  (arvalid_bf),
        .awid_bf     (awid_bf),
        .awvalid_bf  (awvalid_bf),
        .ar_is_faulty(ar_is_faulty),
        .aw_is_faulty(aw_is_faulty)
    );

endmodule

// File: design/bf_fault_select.sv
`timescale 1ns/10ps
`include "bf_defs.svh"

module bf_fault_select import bf_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  bf_mode_t            mode,
    input  bf_addr_t            mask,
    input  bf_addr_t            code,
    input  bf_addr_t            addr_ar,
    input  logic [`BF_ID_W-1:0] arid,
    input  logic                arvalid,
    input  logic [`BF_ID_W-1:0] awid,
    input  logic                awvalid,
    input  logic                ar_member,
    input  logic                aw_member,
    output logic [`BF_ID_W-1:0] arid_bf,
    output logic                arvalid_bf,
    output logic [`BF_ID_W-1:0] awid_bf,
    output logic                awvalid_bf,
    output logic                ar_is_faulty,
    output logic                aw_is_faulty
);

    bf_req_t ar_req;
    bf_req_t aw_req;
    bf_req_t ar_req_q;
    bf_req_t aw_req_q;
    logic    code_match;
    logic    code_match_q;

    assign ar_req     = '{valid: arvalid, id: arid};
    assign aw_req     = '{valid: awvalid, id: awid};
    assign code_match = (mode == MODE_MATCH_CODE) && ((addr_ar & mask) == (code & mask));

    bf_delay_line #(.payload_t(bf_req_t), .DEPTH(`BF_READ_LATENCY)) i_ar_delay (
        .clk  (clk),
        .rst_n(rst_n),
        .din  (ar_req),
        .dout (ar_req_q)
    );

    bf_delay_line #(.payload_t(bf_req_t), .DEPTH(`BF_READ_LATENCY)) i_aw_delay (
        .clk  (clk),
        .rst_n(rst_n),
        .din  (aw_req),
        .dout (aw_req_q)
    );

    // match travels alongside the read request
    bf_delay_line #(.payload_t(logic), .DEPTH(`BF_READ_LATENCY)) i_match_delay (
        .clk  (clk),
        .rst_n(rst_n),
        .din  (code_match),
        .dout (code_match_q)
    );

    assign arid_bf    = ar_req_q.id;
    assign arvalid_bf = ar_req_q.valid;
    assign awid_bf    = aw_req_q.id;
    assign awvalid_bf = aw_req_q.valid;

    // flags use the mode seen when the request leaves
    always_comb begin
        ar_is_faulty = 1'b0;
        aw_is_faulty = 1'b0;
        case (mode)
            MODE_CHECK: begin
                ar_is_faulty = arvalid_bf & ar_member;
                aw_is_faulty = awvalid_bf & aw_member;
            end
            MODE_MATCH_CODE: begin
                ar_is_faulty = arvalid_bf & code_match_q;
                aw_is_faulty = awvalid_bf & aw_member;
            end
            default: begin
                ar_is_faulty = 1'b0;
                aw_is_faulty = 1'b0;
            end
        endcase
    end

endmodule

// File: design/bf_command_decoder.sv
`timescale 1ns/10ps
`include "bf_defs.svh"

module bf_command_decoder import bf_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [`BF_CSR_W-1:0] csr_data,
    output bf_mode_t             mode,
    output bf_addr_t             key,
    output logic                 wr_en,
    output logic                 wr_bit,
    output bf_addr_t             mask,
    output bf_addr_t             code
);

    logic [`BF_CSR_W-1:0] csr_q;
    bf_mode_t             mode_next;
    logic                 is_cmd;
    logic                 code_word;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            csr_q <= '0;
        end else begin
            csr_q <= csr_data;
        end
    end

    // any command word moves the fsm, anything else holds it
    always_comb begin
        mode_next = mode;
        is_cmd    = 1'b1;
        case (csr_q)
            `BF_CMD_IDLE:       mode_next = MODE_IDLE;
            `BF_CMD_INSERT:     mode_next = MODE_INSERT;
            `BF_CMD_REMOVE:     mode_next = MODE_REMOVE;
            `BF_CMD_CHECK:      mode_next = MODE_CHECK;
            `BF_CMD_LOAD_CODE:  mode_next = MODE_LOAD_CODE;
            `BF_CMD_MATCH_CODE: mode_next = MODE_MATCH_CODE;
            default:            is_cmd = 1'b0;
        endcase
    end

    assign code_word = (csr_q[63:59] == `BF_MARK_HI) && (csr_q[4:0] == `BF_MARK_LO);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mode <= MODE_IDLE;
            mask <= '0;
            code <= '0;
        end else begin
            mode <= mode_next;
            if ((mode == MODE_LOAD_CODE) && code_word) begin
                mask <= csr_q[32 +: `BF_ADDR_W];
                code <= csr_q[5 +: `BF_ADDR_W];
            end
        end
    end

    // key sits in bits 33:7 of a data word
    assign key    = csr_q[7 +: `BF_ADDR_W];
    assign wr_en  = ((mode == MODE_INSERT) || (mode == MODE_REMOVE)) && !is_cmd;
    assign wr_bit = (mode == MODE_INSERT);

endmodule

// File: design/bf_channel_lookup.sv
`timescale 1ns/10ps
`include "bf_defs.svh"

module bf_channel_lookup import bf_pkg::*; (
    input  logic     clk,
    input  bf_addr_t addr,
    input  bf_addr_t key,
    input  logic     wr_en,
    input  logic     wr_bit,
    output logic     member
);

    bf_addr_t  hash_in;
    bf_index_t hash_a [`BF_NUM_STACKS];
    bf_index_t hash_b [`BF_NUM_STACKS];

    logic [`BF_NUM_STACKS-1:0] hit_a;
    logic [`BF_NUM_STACKS-1:0] hit_b;

    // filter updates take the ports over from the lookup
    assign hash_in = wr_en ? key : addr;

    bf_hash i_hash (
        .key    (hash_in),
        .hash_a (hash_a),
        .hash_b (hash_b)
    );

    for (genvar i = 0; i < `BF_NUM_STACKS; i++) begin : gen_array
        bf_bit_array i_array (
            .clk    (clk),
            .wr_en  (wr_en),
            .wr_bit (wr_bit),
            .addr_a (hash_a[i]),
            .addr_b (hash_b[i]),
            .q_a    (hit_a[i]),
            .q_b    (hit_b[i])
        );
    end

    // member only when every stack holds both bits
    assign member = (&hit_a) & (&hit_b);

endmodule

// File: design/bf_bit_array.sv
`timescale 1ns/10ps
`include "bf_defs.svh"

module bf_bit_array import bf_pkg::*; (
    input  logic      clk,
    input  logic      wr_en,
    input  logic      wr_bit,
    input  bf_index_t addr_a,
    input  bf_index_t addr_b,
    output logic      q_a,
    output logic      q_b
);

    // block ram powers up cleared
    logic [`BF_FILTER_SIZE-1:0] mem = '0;

    bf_index_t addr_a_q;
    bf_index_t addr_b_q;

    // both ports write the same bit value
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[addr_a] <= wr_bit;
            mem[addr_b] <= wr_bit;
        end
    end

    // registered address, then registered data
    always_ff @(posedge clk) begin
        addr_a_q <= addr_a;
        addr_b_q <= addr_b;
        q_a      <= mem[addr_a_q];
        q_b      <= mem[addr_b_q];
    end

endmodule

// File: design/bf_hash.sv
`timescale 1ns/10ps
`include "bf_defs.svh"

module bf_hash import bf_pkg::*; (
    input  bf_addr_t  key,
    output bf_index_t hash_a [`BF_NUM_STACKS],
    output bf_index_t hash_b [`BF_NUM_STACKS]
);

    logic [31:0] key_ext;

    assign key_ext = {{(32 - `BF_ADDR_W){1'b0}}, key};

    // shifts shrink by one per stack
    for (genvar i = 0; i < `BF_NUM_STACKS; i++) begin : gen_stack
        logic [31:0] xa;
        logic [31:0] ya;
        logic [31:0] xb;
        logic [31:0] yb;

        // xorshift pair
        assign xa = key_ext ^ (key_ext >> (13 - i));
        assign ya = xa ^ (xa >> (7 - i));

        // seeded variant
        assign xb = key_ext ^ `BF_HASH_SEED ^ (key_ext >> (11 - i));
        assign yb = xb ^ (xb >> (3 - i));

        assign hash_a[i] = ya[`BF_INDEX_W-1:0];
        assign hash_b[i] = yb[`BF_INDEX_W-1:0];
    end

endmodule

// File: design/bf_delay_line.sv
`timescale 1ns/10ps

module bf_delay_line #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 2
) (
    input  logic     clk,
    input  logic     rst_n,
    input  payload_t din,
    output payload_t dout
);

    payload_t stage [DEPTH];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage[i] <= '0;
            end
        end else begin
            stage[0] <= din;
            for (int i = 1; i < DEPTH; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign dout = stage[DEPTH-1];

endmodule

// File: design/bf_pkg.sv
`include "bf_defs.svh"

package bf_pkg;

    typedef enum logic [2:0] {
        MODE_IDLE,
        MODE_INSERT,
        MODE_REMOVE,
        MODE_CHECK,
        MODE_LOAD_CODE,
        MODE_MATCH_CODE
    } bf_mode_t;

    typedef logic [`BF_INDEX_W-1:0] bf_index_t;

    typedef logic [`BF_ADDR_W-1:0] bf_addr_t;

    // one request as it moves down the delay line
    typedef struct packed {
        logic                valid;
        logic [`BF_ID_W-1:0] id;
    } bf_req_t;

endpackage

// File: include/bf_defs.svh
`ifndef BF_DEFS_SVH
`define BF_DEFS_SVH

// filter geometry
`define BF_FILTER_SIZE 131072
`define BF_INDEX_W 17
// at most 3 stacks, the last hash shift is 3 - i
`define BF_NUM_STACKS 2

// stream widths
`define BF_ADDR_W 27
`define BF_ID_W 8
`define BF_CSR_W 64

// request to flag delay in cycles
`define BF_READ_LATENCY 2

// command words
`define BF_CMD_IDLE 64'h7EA7BA0F2EA9BA08
`define BF_CMD_INSERT 64'hAFE0D0FDBF0FAFC0
`define BF_CMD_REMOVE 64'hAECF0EAFBEABBCBF
`define BF_CMD_CHECK 64'hFEA0AFE0B0FFA0EF
`define BF_CMD_LOAD_CODE 64'hF0E0FEA0BACFEFAC
`define BF_CMD_MATCH_CODE 64'hCEAFE0AC0FEF0AE0

`define BF_HASH_SEED 32'h811c9dc5

// load-code word markers, bits 63:59 and 4:0
`define BF_MARK_HI 5'b01010
`define BF_MARK_LO 5'b10101

`endif
